// ==== verilog/axi_sram_pkg.sv ====
package axi_sram_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = 4;
    localparam int ID_W      = 4;
    localparam int LEN_W     = 8;
    localparam int MEM_WORDS = 256;
    localparam int WIDX_W    = 8;

    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [STRB_W-1:0] axi_strb_t;
    typedef logic [ID_W-1:0]   axi_id_t;
    typedef logic [LEN_W-1:0]  axi_len_t;
    typedef logic [1:0]        axi_resp_t;
    typedef logic [1:0]        axi_burst_t;
    typedef logic [WIDX_W-1:0] word_idx_t;

    // numeric order doubles as severity order
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;
    localparam axi_burst_t BURST_WRAP  = 2'b10;

    // aw and ar share one request layout
    typedef struct packed {
        axi_addr_t  addr;
        axi_id_t    id;
        axi_len_t   len;
        logic [2:0] size;
        axi_burst_t burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_data_t data;
        axi_id_t   id;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef enum logic [2:0] {
        IDLE,
        RD_FETCH,
        RD_BEAT,
        WR_BEAT,
        WR_RESP
    } ctrl_state_e;

endpackage

// ==== verilog/axi_burst_addr.sv ====
`timescale 1ns/1ps

module axi_burst_addr (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  axi_sram_pkg::axi_addr_t  start,
    input  axi_sram_pkg::axi_burst_t burst,
    input  logic                     step,
    output axi_sram_pkg::word_idx_t  widx,
    output logic                     in_range
);
    import axi_sram_pkg::*;

    // word address, byte offset dropped
    logic [ADDR_W-3:0] waddr_q;
    axi_burst_t        burst_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waddr_q <= '0;
            burst_q <= BURST_FIXED;
        end else if (load) begin
            waddr_q <= start[ADDR_W-1:2];
            burst_q <= burst;
        end else if (step && burst_q == BURST_INCR) begin
            waddr_q <= waddr_q + 1'b1;
        end
    end

    assign widx = waddr_q[WIDX_W-1:0];

    // upper bits set means past the end of the bank
    assign in_range = (waddr_q[ADDR_W-3:WIDX_W] == '0);

endmodule

// ==== verilog/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
    input  logic                    clk,
    input  logic                    rd,
    input  logic                    wr,
    input  axi_sram_pkg::word_idx_t widx,
    input  axi_sram_pkg::axi_strb_t strb,
    input  axi_sram_pkg::axi_data_t wdata,
    output axi_sram_pkg::axi_data_t rdata
);
    import axi_sram_pkg::*;

    axi_data_t mem [MEM_WORDS];

    // one byte lane per strobe bit
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    mem[widx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // word stays put until the next rd
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[widx];
        end
    end

endmodule

// ==== verilog/axi_sram_ctrl.sv ====
`timescale 1ns/1ps

module axi_sram_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    input  axi_sram_pkg::axi_ax_t    aw,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  axi_sram_pkg::axi_w_t     w,
    input  logic                     w_valid,
    output logic                     w_ready,
    output axi_sram_pkg::axi_b_t     b,
    output logic                     b_valid,
    input  logic                     b_ready,
    input  axi_sram_pkg::axi_ax_t    ar,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    output axi_sram_pkg::axi_r_t     r,
    output logic                     r_valid,
    input  logic                     r_ready,

    output logic                     addr_load,
    output axi_sram_pkg::axi_addr_t  addr_start,
    output axi_sram_pkg::axi_burst_t addr_burst,
    output logic                     addr_step,
    input  logic                     in_range,

    output logic                     mem_rd,
    output logic                     mem_wr,
    output axi_sram_pkg::axi_strb_t  mem_strb,
    input  axi_sram_pkg::axi_data_t  rd_word
);
    import axi_sram_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nx;
    axi_len_t    beat_cnt;
    axi_len_t    len_q;
    axi_id_t     id_q;
    axi_burst_t  burst_q;
    axi_resp_t   resp_q;
    axi_resp_t   beat_resp;
    axi_resp_t   w_resp;
    logic        ar_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        r_hs;
    logic        b_hs;
    logic        last_beat;
    logic        beat_ok;

    function automatic axi_resp_t worst(input axi_resp_t x, input axi_resp_t y);
        return (x > y) ? x : y;
    endfunction

    // read wins when both requests wait in idle
    assign ar_ready = (state == IDLE);
    assign aw_ready = (state == IDLE) && !ar_valid;
    assign w_ready  = (state == WR_BEAT);
    assign r_valid  = (state == RD_BEAT);
    assign b_valid  = (state == WR_RESP);

    assign ar_hs = ar_valid && ar_ready;
    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;
    assign r_hs  = r_valid && r_ready;
    assign b_hs  = b_valid && b_ready;

    assign last_beat = (beat_cnt == len_q);

    // per-beat grading, wrap and reserved bursts never touch memory
    always_comb begin
        if (burst_q != BURST_FIXED && burst_q != BURST_INCR) begin
            beat_resp = RESP_SLVERR;
        end else if (!in_range) begin
            beat_resp = RESP_DECERR;
        end else begin
            beat_resp = RESP_OKAY;
        end
    end

    assign beat_ok = (beat_resp == RESP_OKAY);

    // wlast is checked against the count, not used to end the burst
    assign w_resp = worst(beat_resp, (w.last != last_beat) ? RESP_SLVERR : RESP_OKAY);

    assign addr_load  = ar_hs || aw_hs;
    assign addr_start = ar_hs ? ar.addr : aw.addr;
    assign addr_burst = ar_hs ? ar.burst : aw.burst;
    assign addr_step  = r_hs || w_hs;

    assign mem_rd   = (state == RD_FETCH) && beat_ok;
    assign mem_wr   = w_hs && beat_ok;
    assign mem_strb = w.strb;

    assign r = '{
        data: beat_ok ? rd_word : '0,
        id:   id_q,
        resp: beat_resp,
        last: r_valid && last_beat
    };

    assign b = '{id: id_q, resp: resp_q};

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (ar_hs) begin
                    state_nx = RD_FETCH;
                end else if (aw_hs) begin
                    state_nx = WR_BEAT;
                end
            end
            RD_FETCH: state_nx = RD_BEAT;
            RD_BEAT: begin
                if (r_hs) begin
                    state_nx = last_beat ? IDLE : RD_FETCH;
                end
            end
            WR_BEAT: begin
                if (w_hs && last_beat) begin
                    state_nx = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_hs) begin
                    state_nx = IDLE;
                end
            end
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nx;
            if (addr_load) begin
                beat_cnt <= '0;
            end else if (addr_step) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // request fields, held for the whole burst
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            id_q    <= ar.id;
            len_q   <= ar.len;
            burst_q <= ar.burst;
        end else if (aw_hs) begin
            id_q    <= aw.id;
            len_q   <= aw.len;
            burst_q <= aw.burst;
        end
        if (aw_hs) begin
            resp_q <= RESP_OKAY;
        end else if (w_hs) begin
            resp_q <= worst(resp_q, w_resp);
        end
    end

endmodule

// ==== verilog/axi_sram_top.sv ====
`timescale 1ns/1ps

module axi_sram_top (
    input  logic                  clk,
    input  logic                  rst,

    input  axi_sram_pkg::axi_ax_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_sram_pkg::axi_w_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_sram_pkg::axi_b_t  b,
    output logic                  b_valid,
    input  logic                  b_ready,
    input  axi_sram_pkg::axi_ax_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output axi_sram_pkg::axi_r_t  r,
    output logic                  r_valid,
    input  logic                  r_ready
);
    import axi_sram_pkg::*;

    logic       addr_load;
    axi_addr_t  addr_start;
    axi_burst_t addr_burst;
    logic       addr_step;
    word_idx_t  widx;
    logic       in_range;
    logic       mem_rd;
    logic       mem_wr;
    axi_strb_t  mem_strb;
    axi_data_t  rd_word;

    axi_sram_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .addr_load  (addr_load),
        .addr_start (addr_start),
        .addr_burst (addr_burst),
        .addr_step  (addr_step),
        .in_range   (in_range),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_strb   (mem_strb),
        .rd_word    (rd_word)
    );

    axi_burst_addr u_addr (
        .clk      (clk),
        .rst      (rst),
        .load     (addr_load),
        .start    (addr_start),
        .burst    (addr_burst),
        .step     (addr_step),
        .widx     (widx),
        .in_range (in_range)
    );

    // write data straight off the w channel
    sram_bank u_bank (
        .clk   (clk),
        .rd    (mem_rd),
        .wr    (mem_wr),
        .widx  (widx),
        .strb  (mem_strb),
        .wdata (w.data),
        .rdata (rd_word)
    );

endmodule

// ==== testbench/axi_sram_asserts.sv ====
`timescale 1ns/1ps

module axi_sram_asserts (
    input logic                 clk,
    input logic                 rst,
    input axi_sram_pkg::axi_r_t r,
    input logic                 r_valid,
    input logic                 r_ready,
    input axi_sram_pkg::axi_b_t b,
    input logic                 b_valid,
    input logic                 b_ready,
    input logic                 w_ready
);

    // r beat holds under back-pressure
    r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("r beat dropped or changed before r_ready");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("b response dropped or changed before b_ready");

    // one transaction at a time
    no_w_with_r: assert property (@(posedge clk) disable iff (rst)
        !(w_ready && r_valid))
        else $error("w_ready and r_valid high in the same cycle");

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        r.last |-> r_valid)
        else $error("r.last raised without r_valid");

endmodule

bind axi_sram_ctrl axi_sram_asserts u_asserts (.*);

// ==== testbench/axi_sram_tb.sv ====
`timescale 1ns/1ps

module axi_sram_tb;
    import axi_sram_pkg::*;

    localparam int CLK_NS   = 10;
    localparam int FILL_LEN = 64;
    localparam int N_READS  = 20;
    localparam int N_STRB   = 12;
    localparam int N_RANGE  = 4;
    localparam int N_SIMUL  = 4;
    localparam int TXN_COUNT = MEM_WORDS/FILL_LEN + N_READS + 2*N_STRB + 2*N_RANGE + 7
                             + 3*N_SIMUL;
    localparam int BEAT_BOUND = MEM_WORDS + 16*N_READS + 16*N_STRB + 32*N_RANGE + 32 + 24
                              + 24*N_SIMUL;
    // worst case 8 cycles per beat and 12 per transaction
    localparam int WATCHDOG_NS = (8*BEAT_BOUND + 12*TXN_COUNT + 20) * CLK_NS;

    logic    clk;
    logic    rst;
    axi_ax_t aw;
    axi_ax_t ar;
    axi_w_t  w;
    axi_b_t  b;
    axi_r_t  r;
    logic    aw_valid;
    logic    aw_ready;
    logic    w_valid;
    logic    w_ready;
    logic    b_valid;
    logic    b_ready;
    logic    ar_valid;
    logic    ar_ready;
    logic    r_valid;
    logic    r_ready;

    integer     seed = 32'h44ec_27b5;
    logic [7:0] ref_bytes [MEM_WORDS*STRB_W];
    string      test_name;
    int         wready_seen;
    int         rd_done_wready;
    bit         run_passed;
    bit         fail_reported;

    axi_sram_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    // counts cycles with w_ready high, for the read priority check
    always @(negedge clk) begin
        if (w_ready) begin
            wready_seen <= wready_seen + 1;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned v;
        v = $random(seed);
        return v % n;
    endfunction

    function automatic logic [ADDR_W-3:0] beat_waddr(input axi_addr_t addr,
                                                     input axi_burst_t burst, input int k);
        if (burst == BURST_INCR) begin
            return addr[ADDR_W-1:2] + (ADDR_W-2)'(k);
        end
        return addr[ADDR_W-1:2];
    endfunction

    function automatic axi_resp_t expect_beat_resp(input axi_addr_t addr,
                                                   input axi_burst_t burst, input int k);
        if (burst != BURST_FIXED && burst != BURST_INCR) begin
            return RESP_SLVERR;
        end
        if (beat_waddr(addr, burst, k) >= (ADDR_W-2)'(MEM_WORDS)) begin
            return RESP_DECERR;
        end
        return RESP_OKAY;
    endfunction

    // decerr outranks slverr, slverr outranks okay
    function automatic axi_resp_t merge_resp(input axi_resp_t acc, input axi_resp_t beat);
        if (acc == RESP_DECERR || beat == RESP_DECERR) begin
            return RESP_DECERR;
        end
        if (acc == RESP_SLVERR || beat == RESP_SLVERR) begin
            return RESP_SLVERR;
        end
        return RESP_OKAY;
    endfunction

    function automatic axi_data_t ref_word(input logic [ADDR_W-3:0] wa);
        int base;
        base = STRB_W * int'(wa);
        return {ref_bytes[base+3], ref_bytes[base+2], ref_bytes[base+1], ref_bytes[base]};
    endfunction

    task automatic stop_with_failure();
        fail_reported = 1'b1;
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic do_write(input axi_addr_t addr, input axi_len_t len, input axi_burst_t burst,
                            input bit rand_strb, input bit bad_last, input bit no_delay);
        axi_id_t           id;
        axi_resp_t         exp_resp;
        axi_resp_t         beat_resp;
        axi_strb_t         strb;
        axi_data_t         data;
        logic [ADDR_W-3:0] wa;
        bit                hs;
        id = axi_id_t'(rand_below(16));
        exp_resp = RESP_OKAY;
        if (!no_delay) begin
            repeat (rand_below(3)) next_cycle();
        end
        aw = '{addr: addr, id: id, len: len, size: 3'd2, burst: burst};
        aw_valid = 1'b1;
        do begin
            @(negedge clk);
            hs = aw_ready;
            next_cycle();
        end while (!hs);
        aw_valid = 1'b0;
        for (int k = 0; k <= int'(len); k++) begin
            repeat (rand_below(3)) next_cycle();
            data = $random(seed);
            strb = rand_strb ? axi_strb_t'(rand_below(16)) : '1;
            w = '{data: data, strb: strb, last: (k == int'(len)) && !bad_last};
            w_valid = 1'b1;
            do begin
                @(negedge clk);
                hs = w_ready;
                next_cycle();
            end while (!hs);
            w_valid = 1'b0;
            beat_resp = expect_beat_resp(addr, burst, k);
            if (beat_resp == RESP_OKAY) begin
                wa = beat_waddr(addr, burst, k);
                for (int i = 0; i < STRB_W; i++) begin
                    if (strb[i]) begin
                        ref_bytes[STRB_W*int'(wa) + i] = data[8*i +: 8];
                    end
                end
            end
            exp_resp = merge_resp(exp_resp, beat_resp);
        end
        if (bad_last) begin
            exp_resp = merge_resp(exp_resp, RESP_SLVERR);
        end
        do begin
            b_ready = (rand_below(4) != 0);
            @(negedge clk);
            hs = b_valid && b_ready;
            if (hs) begin
                check_value("bresp", 32'(exp_resp), 32'(b.resp));
                check_value("bid", 32'(id), 32'(b.id));
            end
            next_cycle();
        end while (!hs);
        b_ready = 1'b0;
    endtask

    task automatic do_read(input axi_addr_t addr, input axi_len_t len, input axi_burst_t burst,
                           input bit no_delay);
        axi_id_t   id;
        axi_resp_t beat_resp;
        axi_data_t exp_data;
        bit        hs;
        id = axi_id_t'(rand_below(16));
        if (!no_delay) begin
            repeat (rand_below(3)) next_cycle();
        end
        ar = '{addr: addr, id: id, len: len, size: 3'd2, burst: burst};
        ar_valid = 1'b1;
        do begin
            @(negedge clk);
            hs = ar_ready;
            next_cycle();
        end while (!hs);
        ar_valid = 1'b0;
        for (int k = 0; k <= int'(len); k++) begin
            beat_resp = expect_beat_resp(addr, burst, k);
            exp_data = (beat_resp == RESP_OKAY) ? ref_word(beat_waddr(addr, burst, k)) : '0;
            do begin
                r_ready = (rand_below(4) != 0);
                @(negedge clk);
                hs = r_valid && r_ready;
                if (hs) begin
                    check_value("rdata", exp_data, r.data);
                    check_value("rresp", 32'(beat_resp), 32'(r.resp));
                    check_value("rid", 32'(id), 32'(r.id));
                    check_value("rlast", 32'(k == int'(len)), 32'(r.last));
                    if (k == int'(len)) begin
                        rd_done_wready = wready_seen;
                    end
                end
                next_cycle();
            end while (!hs);
        end
        r_ready = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
        stop_with_failure();
    end

    initial begin
        int         len_i;
        int         start_i;
        int         snap;
        axi_burst_t bt;
        rst = 1'b1;
        aw = '0;
        ar = '0;
        w = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("ready/valid after reset", 32'(5'b11000),
                    32'({ar_ready, aw_ready, w_ready, r_valid, b_valid}));

        test_name = "fill";
        for (int i = 0; i < MEM_WORDS/FILL_LEN; i++) begin
            do_write(axi_addr_t'(4*FILL_LEN*i), axi_len_t'(FILL_LEN-1), BURST_INCR,
                     1'b0, 1'b0, 1'b0);
        end

        test_name = "incr_read";
        for (int i = 0; i < N_READS; i++) begin
            len_i = rand_below(16);
            start_i = rand_below(MEM_WORDS - len_i);
            do_read(axi_addr_t'(4*start_i + rand_below(4)), axi_len_t'(len_i), BURST_INCR, 1'b0);
        end

        // fixed bursts keep only the last beat per byte
        test_name = "strobe";
        for (int i = 0; i < N_STRB; i++) begin
            len_i = rand_below(8);
            start_i = rand_below(MEM_WORDS - len_i);
            bt = (rand_below(2) != 0) ? BURST_FIXED : BURST_INCR;
            do_write(axi_addr_t'(4*start_i), axi_len_t'(len_i), bt, 1'b1, 1'b0, 1'b0);
            do_read(axi_addr_t'(4*start_i), axi_len_t'(len_i), BURST_INCR, 1'b0);
        end

        test_name = "decerr";
        for (int i = 0; i < N_RANGE; i++) begin
            len_i = 4 + rand_below(12);
            start_i = MEM_WORDS - 3 + 2*i;
            bt = (i == N_RANGE-1) ? BURST_FIXED : BURST_INCR;
            do_write(axi_addr_t'(4*start_i), axi_len_t'(len_i), bt, 1'b1, 1'b0, 1'b0);
            do_read(axi_addr_t'(4*start_i), axi_len_t'(len_i), bt, 1'b0);
        end
        // low words would show any aliased out-of-range write
        do_read('0, axi_len_t'(31), BURST_INCR, 1'b0);

        test_name = "wrap";
        do_write(axi_addr_t'(64), axi_len_t'(3), BURST_WRAP, 1'b1, 1'b0, 1'b0);
        do_read(axi_addr_t'(64), axi_len_t'(3), BURST_WRAP, 1'b0);
        do_read(axi_addr_t'(64), axi_len_t'(3), BURST_INCR, 1'b0);

        test_name = "bad_wlast";
        do_write(axi_addr_t'(128), axi_len_t'(2), BURST_INCR, 1'b0, 1'b1, 1'b0);
        do_read(axi_addr_t'(128), axi_len_t'(2), BURST_INCR, 1'b0);
        do_write(axi_addr_t'(192), axi_len_t'(0), BURST_INCR, 1'b0, 1'b1, 1'b0);

        test_name = "simultaneous";
        for (int i = 0; i < N_SIMUL; i++) begin
            len_i = rand_below(8);
            start_i = rand_below(MEM_WORDS - len_i);
            snap = wready_seen;
            fork
                do_read(axi_addr_t'(4*start_i), axi_len_t'(len_i), BURST_INCR, 1'b1);
                do_write(axi_addr_t'(4*start_i), axi_len_t'(len_i), BURST_INCR,
                         1'b1, 1'b0, 1'b1);
            join
            assert (rd_done_wready == snap) else begin
                $display("write data was accepted before the competing read finished");
                stop_with_failure();
            end
            do_read(axi_addr_t'(4*start_i), axi_len_t'(len_i), BURST_INCR, 1'b0);
        end

        run_passed = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    // a run stopped by a bound assertion ends here without a verdict line
    final begin
        if (!run_passed && !fail_reported) begin
            $display("*** TEST FAILED ***");
        end
    end

endmodule

// ==== src.f ====
verilog/axi_sram_pkg.sv
verilog/axi_burst_addr.sv
verilog/sram_bank.sv
verilog/axi_sram_ctrl.sv
verilog/axi_sram_top.sv
testbench/axi_sram_asserts.sv
testbench/axi_sram_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the AXI SRAM testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

TOP=axi_sram_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "run.sh: simulation passed"
    exit 0
fi

echo "run.sh: simulation failed, see $LOG"
exit 1
